// ==== hdr_result_if.sv ====
/* Per-header check flags from the checksum and field paths to the classifier */

`timescale 1ns/1ps

interface hdr_result_if;

    // Set for one cycle per checked header
    logic valid;
    logic csum_ok;
    logic version_ok;
    logic ihl_ok;
    logic ttl_ok;

    // Checksum path owns the strobe
    modport csum_src (output valid, output csum_ok);

    // Field path flags line up with the strobe
    modport field_src (output version_ok, output ihl_ok, output ttl_ok);

    modport sink (
        input valid,
        input csum_ok,
        input version_ok,
        input ihl_ok,
        input ttl_ok
    );

endinterface

// ==== ipv4_checksum_verify.sv ====
/* IPv4 header checksum check
   Three-stage one's-complement sum over the ten header words */

`timescale 1ns/1ps
`include "ipv4_defs.svh"

module ipv4_checksum_verify (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hdr_valid,
    input  ipv4_pkg::ipv4_header_t hdr,
    hdr_result_if.csum_src         res
);

    localparam int NUM_WORDS = `IPV4_HDR_BITS / 16;
    localparam int NUM_PAIRS = NUM_WORDS / 2;

    logic [`IPV4_HDR_BITS-1:0] hdr_bits;
    logic [15:0]               words [NUM_WORDS];
    logic [16:0]               pair_sum [NUM_PAIRS];
    logic [19:0]               total_sum;
    logic [19:0]               total_q;
    logic [16:0]               fold_1;
    logic [15:0]               fold_2;
    logic                      csum_ok_q;
    logic [`CSUM_STAGES-1:0]   vld_sr;

    assign hdr_bits = hdr;

    // Split into 16-bit words with the first word on the wire at index 0
    always_comb begin
        for (int i = 0; i < NUM_WORDS; i++) begin
            words[i] = hdr_bits[`IPV4_HDR_BITS-1-16*i -: 16];
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 1 pairwise sums

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_PAIRS; i++) begin
            pair_sum[i] <= {1'b0, words[2*i]} + {1'b0, words[2*i+1]};
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2 adds the five partial sums
    // Twenty bits hold the worst case

    always_comb begin
        total_sum = '0;
        for (int i = 0; i < NUM_PAIRS; i++) begin
            total_sum = total_sum + {3'b000, pair_sum[i]};
        end
    end

    always_ff @(posedge clk) begin
        total_q <= total_sum;
    end

    ////////////////////////////////////////////////////////////
    // Stage 3 folds the end-around carries and tests for all ones

    assign fold_1 = {1'b0, total_q[15:0]} + {13'd0, total_q[19:16]};
    // Second fold cannot carry out again
    assign fold_2 = fold_1[15:0] + {15'd0, fold_1[16]};

    always_ff @(posedge clk) begin
        csum_ok_q <= (fold_2 == 16'hFFFF);
    end

    // Valid bit rides beside the data
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[`CSUM_STAGES-2:0], hdr_valid};
        end
    end

    assign res.valid   = vld_sr[`CSUM_STAGES-1];
    assign res.csum_ok = csum_ok_q;

    a_csum_known: assert property (
        @(posedge clk) disable iff (rst)
        res.valid |-> !$isunknown(res.csum_ok)
    );

endmodule

// ==== ipv4_defs.svh ====
/* IPv4 receive checker constants: protocol field values and pipeline depth */

`ifndef IPV4_DEFS_SVH
`define IPV4_DEFS_SVH

// Version nibble every accepted header must carry
`define IPV4_VERSION 4'd4

// Only header length accepted, in 32-bit words (no options)
`define IPV4_IHL 4'd5

// Full header width, 20 bytes
`define IPV4_HDR_BITS 160

// Register stages in the checksum and field paths
`define CSUM_STAGES 3

`endif

// ==== ipv4_field_check.sv ====
/* IPv4 version, IHL and TTL checks
   Flags are delayed to meet the checksum result in the same cycle */

`timescale 1ns/1ps
`include "ipv4_defs.svh"

module ipv4_field_check (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hdr_valid,
    input  ipv4_pkg::ipv4_header_t hdr,
    hdr_result_if.field_src        res
);

    logic                    ver_match;
    logic                    ihl_match;
    logic                    ttl_live;
    // Flag order is {version, ihl, ttl}
    logic [2:0]              flag_q [`CSUM_STAGES];
    logic [`CSUM_STAGES-2:0] vld_q;

    ////////////////////////////////////////////////////////////
    // Field compares

    assign ver_match = (hdr.version == `IPV4_VERSION);
    assign ihl_match = (hdr.hdr_len == `IPV4_IHL);
    assign ttl_live  = (hdr.ttl != 8'd0);

    // Tracks which stages hold a header
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[`CSUM_STAGES-3:0], hdr_valid};
        end
    end

    ////////////////////////////////////////////////////////////
    // Flag pipeline, each stage loads only when a header arrives

    always_ff @(posedge clk) begin
        if (hdr_valid) begin
            flag_q[0] <= {ver_match, ihl_match, ttl_live};
        end
        for (int k = 1; k < `CSUM_STAGES; k++) begin
            if (vld_q[k-1]) begin
                flag_q[k] <= flag_q[k-1];
            end
        end
    end

    assign res.version_ok = flag_q[`CSUM_STAGES-1][2];
    assign res.ihl_ok     = flag_q[`CSUM_STAGES-1][1];
    assign res.ttl_ok     = flag_q[`CSUM_STAGES-1][0];

endmodule

// ==== ipv4_hdr_classify.sv ====
/* IPv4 header classifier
   Priority-encodes the check flags and keeps saturating good/bad counts */

`timescale 1ns/1ps

module ipv4_hdr_classify (
    input  logic                  clk,
    input  logic                  rst,
    hdr_result_if.sink            res,
    output logic                  status_valid,
    output ipv4_pkg::hdr_status_e status,
    output logic [15:0]           good_count,
    output logic [15:0]           bad_count
);

    import ipv4_pkg::*;

    hdr_status_e status_next;
    logic        good_sat;
    logic        bad_sat;

    ////////////////////////////////////////////////////////////
    // Status priority

    // Version beats IHL beats checksum beats TTL
    always_comb begin
        if (!res.version_ok) begin
            status_next = HDR_BAD_VERSION;
        end else if (!res.ihl_ok) begin
            status_next = HDR_BAD_IHL;
        end else if (!res.csum_ok) begin
            status_next = HDR_BAD_CHECKSUM;
        end else if (!res.ttl_ok) begin
            status_next = HDR_TTL_EXPIRED;
        end else begin
            status_next = HDR_OK;
        end
    end

    always_ff @(posedge clk) begin
        if (res.valid) begin
            status <= status_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status_valid <= 1'b0;
        end else begin
            status_valid <= res.valid;
        end
    end

    ////////////////////////////////////////////////////////////
    // Counters, held at all ones once full

    assign good_sat = (good_count == 16'hFFFF);
    assign bad_sat  = (bad_count == 16'hFFFF);

    always_ff @(posedge clk) begin
        if (rst) begin
            good_count <= '0;
            bad_count  <= '0;
        end else if (res.valid) begin
            if (status_next == HDR_OK) begin
                if (!good_sat) begin
                    good_count <= good_count + 16'd1;
                end
            end else if (!bad_sat) begin
                bad_count <= bad_count + 16'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks

    a_idle_after_rst: assert property (
        @(posedge clk) $past(rst) |-> !status_valid
    );

    a_valid_follows: assert property (
        @(posedge clk) disable iff (rst)
        res.valid |=> status_valid
    );

    a_no_spurious: assert property (
        @(posedge clk) disable iff (rst)
        status_valid |-> $past(res.valid)
    );

endmodule

// ==== ipv4_hdr_rx.sv ====
/* IPv4 receive header checker top
   Checksum and field paths feeding one classifier, no back-pressure */

`timescale 1ns/1ps

module ipv4_hdr_rx (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hdr_valid,
    input  ipv4_pkg::ipv4_header_t hdr,
    output logic                   status_valid,
    output ipv4_pkg::hdr_status_e  status,
    output logic [15:0]            good_count,
    output logic [15:0]            bad_count
);

    // Flags from both paths meet here
    hdr_result_if res_if ();

    ////////////////////////////////////////////////////////////
    // Checking paths

    ipv4_checksum_verify u_checksum (
        .clk       (clk),
        .rst       (rst),
        .hdr_valid (hdr_valid),
        .hdr       (hdr),
        .res       (res_if.csum_src)
    );

    ipv4_field_check u_fields (
        .clk       (clk),
        .rst       (rst),
        .hdr_valid (hdr_valid),
        .hdr       (hdr),
        .res       (res_if.field_src)
    );

    ////////////////////////////////////////////////////////////
    // Classification and counts

    ipv4_hdr_classify u_classify (
        .clk          (clk),
        .rst          (rst),
        .res          (res_if.sink),
        .status_valid (status_valid),
        .status       (status),
        .good_count   (good_count),
        .bad_count    (bad_count)
    );

endmodule

// ==== ipv4_pkg.sv ====
/* IPv4 header checker types
   Header layout in wire order and the per-header status code */

package ipv4_pkg;

    ////////////////////////////////////////////////////////////
    // Header layout, most significant field first

    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  hdr_len;
        logic [7:0]  tos;
        logic [15:0] length;
        logic [15:0] id;
        logic [2:0]  flags;
        logic [12:0] offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_chk;
        logic [31:0] src;
        logic [31:0] dst;
    } ipv4_header_t;

    ////////////////////////////////////////////////////////////
    // Result of checking one header

    typedef enum logic [2:0] {
        HDR_OK           = 3'd0,
        HDR_BAD_VERSION  = 3'd1,
        HDR_BAD_IHL      = 3'd2,
        HDR_BAD_CHECKSUM = 3'd3,
        // TTL of zero on arrival
        HDR_TTL_EXPIRED  = 3'd4
    } hdr_status_e;

endpackage

// ==== tb.f ====
+incdir+.
ipv4_pkg.sv
hdr_result_if.sv
ipv4_checksum_verify.sv
ipv4_field_check.sv
ipv4_hdr_classify.sv
ipv4_hdr_rx.sv
tb_ipv4_hdr_rx.sv

// ==== tb_ipv4_hdr_rx.sv ====
/* Testbench for the IPv4 receive header checker
   Random headers checked against a reference model and an expected-status queue */

`timescale 1ns/1ps
`include "ipv4_defs.svh"

module tb_ipv4_hdr_rx;

    import ipv4_pkg::*;

    // Covers about 700 headers with gaps of up to 3 cycles plus drains and resets
    localparam int MAX_CYCLES = 3000;
    localparam int LATENCY    = `CSUM_STAGES + 1;

    logic         clk;
    logic         rst;
    logic         hdr_valid;
    ipv4_header_t hdr_in;
    logic         status_valid;
    hdr_status_e  status;
    logic [15:0]  good_count;
    logic [15:0]  bad_count;

    integer      seed = 19;
    int          cycles;
    int          errors;
    int          pass_tests;
    int          fail_tests;
    logic [15:0] model_good;
    logic [15:0] model_bad;
    hdr_status_e exp_q [$];
    int          due_q [$];

    ipv4_hdr_rx dut (
        .clk          (clk),
        .rst          (rst),
        .hdr_valid    (hdr_valid),
        .hdr          (hdr_in),
        .status_valid (status_valid),
        .status       (status),
        .good_count   (good_count),
        .bad_count    (bad_count)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped: no finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model

    // One's-complement sum of the ten words with the carry wrapped after each add
    function automatic logic [15:0] ones_sum(input ipv4_header_t h);
        logic [159:0] bits;
        logic [16:0]  acc;
        bits = h;
        acc  = '0;
        for (int i = 0; i < 10; i++) begin
            acc = {1'b0, acc[15:0]} + {1'b0, bits[159-16*i -: 16]};
            acc = {1'b0, acc[15:0]} + {16'd0, acc[16]};
        end
        return acc[15:0];
    endfunction

    // Mask bit 0 corrupts the version, bit 1 the IHL, bit 2 the TTL and bit 3 the checksum
    function automatic ipv4_header_t build_header(input logic [3:0] mask);
        ipv4_header_t h;
        h = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
        h.version = `IPV4_VERSION;
        h.hdr_len = `IPV4_IHL;
        if (h.ttl == 8'd0) begin
            h.ttl = 8'd1;
        end
        if (mask[0]) begin
            while (h.version == `IPV4_VERSION) begin
                h.version = $random(seed);
            end
        end
        if (mask[1]) begin
            while (h.hdr_len == `IPV4_IHL) begin
                h.hdr_len = $random(seed);
            end
        end
        if (mask[2]) begin
            h.ttl = 8'd0;
        end
        h.hdr_chk = 16'd0;
        h.hdr_chk = ~ones_sum(h);
        if (mask[3]) begin
            h.hdr_chk = $random(seed);
            // Nudge away from any value that still sums to all ones
            while (ones_sum(h) == 16'hFFFF) begin
                h.hdr_chk = h.hdr_chk + 16'd1;
            end
        end
        return h;
    endfunction

    function automatic hdr_status_e predict_status(input ipv4_header_t h);
        if (h.version != `IPV4_VERSION) begin
            return HDR_BAD_VERSION;
        end else if (h.hdr_len != `IPV4_IHL) begin
            return HDR_BAD_IHL;
        end else if (ones_sum(h) != 16'hFFFF) begin
            return HDR_BAD_CHECKSUM;
        end else if (h.ttl == 8'd0) begin
            return HDR_TTL_EXPIRED;
        end
        return HDR_OK;
    endfunction

    ////////////////////////////////////////////////////////////
    // Output monitor

    always @(negedge clk) begin
        if (!rst && status_valid) begin
            if (exp_q.size() == 0) begin
                $display("status_valid rose at cycle %0d with no header outstanding", cycles);
                errors = errors + 1;
            end else begin
                if (due_q[0] != cycles) begin
                    $display("Status came at cycle %0d instead of cycle %0d", cycles, due_q[0]);
                    errors = errors + 1;
                end
                if (status != exp_q[0]) begin
                    $display("ERR status exp=%h got=%h", exp_q[0], status);
                    errors = errors + 1;
                end
                if (exp_q[0] == HDR_OK) begin
                    if (model_good != 16'hFFFF) begin
                        model_good = model_good + 16'd1;
                    end
                end else if (model_bad != 16'hFFFF) begin
                    model_bad = model_bad + 16'd1;
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
                if (good_count != model_good) begin
                    $display("ERR good_count exp=%h got=%h", model_good, good_count);
                    errors = errors + 1;
                end
                if (bad_count != model_bad) begin
                    $display("ERR bad_count exp=%h got=%h", model_bad, bad_count);
                    errors = errors + 1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks

    task automatic send_header(input logic [3:0] mask);
        ipv4_header_t h;
        h = build_header(mask);
        @(negedge clk);
        hdr_valid = 1'b1;
        hdr_in    = h;
        exp_q.push_back(predict_status(h));
        due_q.push_back(cycles + LATENCY);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            hdr_valid = 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Kind 0 is clean, 1 has a bad checksum, 2 random corruption and 3 a mix
    task automatic run_headers(input int count, input int kind, input int max_gap);
        logic [3:0] mask;
        for (int i = 0; i < count; i++) begin
            case (kind)
                0: mask = 4'b0000;
                1: mask = 4'b1000;
                default: begin
                    mask = $random(seed);
                    if (kind == 2 && mask == 4'b0000) begin
                        mask = 4'b1000;
                    end
                    if (kind == 3 && $random(seed) % 2 == 0) begin
                        mask = 4'b0000;
                    end
                end
            endcase
            send_header(mask);
            if (max_gap > 0) begin
                idle({$random(seed)} % (max_gap + 1));
            end
        end
        drain();
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst       = 1'b1;
        hdr_valid = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        exp_q.delete();
        due_q.delete();
        model_good = '0;
        model_bad  = '0;
    endtask

    task automatic check_idle_after_reset();
        if (status_valid !== 1'b0) begin
            $display("status_valid is high right after reset");
            errors = errors + 1;
        end
        if (good_count !== 16'd0) begin
            $display("ERR good_count exp=%h got=%h", 16'd0, good_count);
            errors = errors + 1;
        end
        if (bad_count !== 16'd0) begin
            $display("ERR bad_count exp=%h got=%h", 16'd0, bad_count);
            errors = errors + 1;
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            $display("Test %0d %s: ok", num, name);
            pass_tests = pass_tests + 1;
        end else begin
            $display("Test %0d %s: %0d errors", num, name, errors - err_before);
            fail_tests = fail_tests + 1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int          mark;
        int          reset_errs;
        logic [15:0] bad_before;
        clk        = 1'b0;
        rst        = 1'b1;
        hdr_valid  = 1'b0;
        hdr_in     = '0;
        cycles     = 0;
        errors     = 0;
        pass_tests = 0;
        fail_tests = 0;
        model_good = '0;
        model_bad  = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        mark = errors;
        check_idle_after_reset();
        reset_errs = errors - mark;

        mark = errors;
        run_headers(150, 0, 3);
        if (good_count != 16'd150) begin
            $display("ERR good_count exp=%h got=%h", 16'd150, good_count);
            errors = errors + 1;
        end
        report_test(1, "clean headers", mark);

        mark = errors;
        bad_before = bad_count;
        run_headers(150, 1, 3);
        if (bad_count - bad_before != 16'd150) begin
            $display("ERR bad_count exp=%h got=%h", bad_before + 16'd150, bad_count);
            errors = errors + 1;
        end
        report_test(2, "bad checksum", mark);

        mark = errors;
        run_headers(150, 2, 3);
        report_test(3, "field corruption", mark);

        mark = errors;
        run_headers(200, 3, 0);
        report_test(4, "back-to-back mix", mark);

        // Second reset lands with two headers in flight and counting restarts from zero
        mark = errors - reset_errs;
        send_header(4'b0000);
        send_header(4'b1000);
        apply_reset();
        check_idle_after_reset();
        run_headers(20, 3, 2);
        report_test(5, "reset behavior", mark);

        $display("Tests passed %0d, failed %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
